// ==== freq_mon_pkg.sv ====
package freq_mon_pkg;

    localparam int CNT_W       = 32;
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // Register map, byte addresses
    localparam logic [AXIL_ADDR_W-1:0] REG_GATE_LEN = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_ADC_FREQ = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_REF_FREQ = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 4'hC;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Master to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

// ==== pulse_sync.sv ====
`timescale 1ns/100ps

module pulse_sync (
    input  logic src_clk_i,
    input  logic dst_clk_i,
    input  logic arst_n_i,
    input  logic src_pulse_i,
    output logic dst_pulse_o
);

    logic       toggle_q;
    logic [2:0] sync_q;

    // Each source pulse flips the level
    always_ff @(posedge src_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            toggle_q <= 1'b0;
        end else if (src_pulse_i) begin
            toggle_q <= ~toggle_q;
        end
    end

    always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], toggle_q};
        end
    end

    // Any change of the synced level is one pulse
    assign dst_pulse_o = sync_q[2] ^ sync_q[1];

endmodule

// ==== gate_timer.sv ====
`timescale 1ns/100ps

module gate_timer import freq_mon_pkg::*; (
    input  logic             ps_clk,
    input  logic             arst_n_i,
    input  logic [CNT_W-1:0] gate_len_i,
    input  logic             gate_restart_i,
    output logic             gate_pulse_o
);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q        <= '0;
            gate_pulse_o <= 1'b0;
        end else if (gate_restart_i) begin
            cnt_q        <= gate_len_i - 1'b1; // Next gate a full interval away
            gate_pulse_o <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q        <= gate_len_i - 1'b1;
            gate_pulse_o <= 1'b1;
        end else begin
            cnt_q        <= cnt_q - 1'b1;
            gate_pulse_o <= 1'b0;
        end
    end

endmodule

// ==== clk_meter.sv ====
`timescale 1ns/100ps

module clk_meter import freq_mon_pkg::*; (
    input  logic             ps_clk,
    input  logic             meas_clk_i,
    input  logic             arst_n_i,
    input  logic             gate_pulse_i,
    output logic [CNT_W-1:0] count_o,
    output logic             result_valid_o
);

    logic             gate_meas;    // Gate in the measured domain
    logic             ready_ps;     // Latched count is stable, seen in ps_clk
    logic [CNT_W-1:0] edge_cnt_q;
    logic [CNT_W-1:0] latch_q;

    pulse_sync u_gate_sync (
        .src_clk_i   (ps_clk),
        .dst_clk_i   (meas_clk_i),
        .arst_n_i    (arst_n_i),
        .src_pulse_i (gate_pulse_i),
        .dst_pulse_o (gate_meas)
    );

    // Gate edge itself counts as the last edge of the interval
    always_ff @(posedge meas_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            edge_cnt_q <= '0;
        end else if (gate_meas) begin
            edge_cnt_q <= '0;
        end else begin
            edge_cnt_q <= edge_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge meas_clk_i) begin
        if (gate_meas) latch_q <= edge_cnt_q + 1'b1;
    end

    pulse_sync u_ready_sync (
        .src_clk_i   (meas_clk_i),
        .dst_clk_i   (ps_clk),
        .arst_n_i    (arst_n_i),
        .src_pulse_i (gate_meas),
        .dst_pulse_o (ready_ps)
    );

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_o        <= '0;
            result_valid_o <= 1'b0;
        end else begin
            if (ready_ps) count_o <= latch_q; // Held since the gate, safe to cross
            result_valid_o <= ready_ps;
        end
    end

endmodule

// ==== axil_regs.sv ====
`timescale 1ns/100ps

module axil_regs import freq_mon_pkg::*; #(
    parameter logic [CNT_W-1:0] GATE_DEFAULT = 200
) (
    input  logic             ps_clk,
    input  logic             arst_n_i,
    input  axil_req_t        axil_req_i,
    output axil_rsp_t        axil_rsp_o,
    input  logic [CNT_W-1:0] adc_count_i,
    input  logic [CNT_W-1:0] ref_count_i,
    input  logic             adc_valid_i,
    input  logic             ref_valid_i,
    output logic [CNT_W-1:0] gate_len_o,
    output logic             gate_restart_o
);

    logic                   awready_q;
    logic                   bvalid_q;
    logic                   arready_q;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [AXIL_DATA_W-1:0] rd_mux;
    logic                   wr_en;
    logic                   rd_en;
    logic                   adc_new_q;
    logic                   ref_new_q;

    assign wr_en = awready_q && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_en = arready_q && axil_req_i.arvalid;

    // Write channel, AW and W taken together
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            awready_q <= axil_req_i.awvalid && axil_req_i.wvalid && !awready_q && !bvalid_q;
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gate_len_o     <= GATE_DEFAULT;
            gate_restart_o <= 1'b0;
        end else begin
            gate_restart_o <= wr_en && (axil_req_i.awaddr == REG_GATE_LEN);
            if (wr_en && (axil_req_i.awaddr == REG_GATE_LEN)) begin
                for (int i = 0; i < AXIL_DATA_W/8; i++) begin
                    if (axil_req_i.wstrb[i]) gate_len_o[8*i +: 8] <= axil_req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        case (axil_req_i.araddr)
            REG_GATE_LEN: rd_mux = gate_len_o;
            REG_ADC_FREQ: rd_mux = adc_count_i;
            REG_REF_FREQ: rd_mux = ref_count_i;
            REG_STATUS:   rd_mux = {{(AXIL_DATA_W-2){1'b0}}, ref_new_q, adc_new_q};
            default:      rd_mux = '0;
        endcase
    end

    // Read channel, data held until rready
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= axil_req_i.arvalid && !arready_q && !rvalid_q;
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (rd_en) rdata_q <= rd_mux;
    end

    // Sticky result flags, set wins over clear
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            adc_new_q <= 1'b0;
            ref_new_q <= 1'b0;
        end else begin
            if (adc_valid_i) begin
                adc_new_q <= 1'b1;
            end else if (rd_en && (axil_req_i.araddr == REG_ADC_FREQ)) begin
                adc_new_q <= 1'b0;
            end
            if (ref_valid_i) begin
                ref_new_q <= 1'b1;
            end else if (rd_en && (axil_req_i.araddr == REG_REF_FREQ)) begin
                ref_new_q <= 1'b0;
            end
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready_q;
        axil_rsp_o.wready  = awready_q;
        axil_rsp_o.bresp   = RESP_OKAY;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = arready_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = RESP_OKAY;
        axil_rsp_o.rvalid  = rvalid_q;
    end

endmodule

// ==== freq_mon_top.sv ====
`timescale 1ns/100ps

module freq_mon_top import freq_mon_pkg::*; #(
    parameter logic [CNT_W-1:0] GATE_DEFAULT = 200
) (
    input  logic      ps_clk,
    input  logic      arst_n_i,
    input  logic      adc_clk_i,
    input  logic      ref_clk_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o
);

    logic [CNT_W-1:0] gate_len;
    logic             gate_restart;
    logic             gate_pulse;
    logic [CNT_W-1:0] adc_count;
    logic [CNT_W-1:0] ref_count;
    logic             adc_valid;
    logic             ref_valid;

    gate_timer u_gate_timer (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .gate_len_i     (gate_len),
        .gate_restart_i (gate_restart),
        .gate_pulse_o   (gate_pulse)
    );

    clk_meter u_adc_meter (
        .ps_clk         (ps_clk),
        .meas_clk_i     (adc_clk_i),
        .arst_n_i       (arst_n_i),
        .gate_pulse_i   (gate_pulse),
        .count_o        (adc_count),
        .result_valid_o (adc_valid)
    );

    clk_meter u_ref_meter (
        .ps_clk         (ps_clk),
        .meas_clk_i     (ref_clk_i),
        .arst_n_i       (arst_n_i),
        .gate_pulse_i   (gate_pulse),
        .count_o        (ref_count),
        .result_valid_o (ref_valid)
    );

    axil_regs #(
        .GATE_DEFAULT (GATE_DEFAULT)
    ) u_axil_regs (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .adc_count_i    (adc_count),
        .ref_count_i    (ref_count),
        .adc_valid_i    (adc_valid),
        .ref_valid_i    (ref_valid),
        .gate_len_o     (gate_len),
        .gate_restart_o (gate_restart)
    );

endmodule

// ==== tb_freq_mon.sv ====
`timescale 1ns/100ps

module tb_freq_mon import freq_mon_pkg::*; ();

    localparam int          GATE_DEFAULT = 200;
    localparam int          NUM_ROWS     = 4;
    localparam int          HS_LIMIT     = 16;  // Cycles to wait for a ready
    localparam bit          WR           = 1'b1;
    localparam bit          RD           = 1'b0;
    localparam logic [31:0] SEED         = 32'hb282_38e2;

    typedef struct packed {
        int adc_period;  // ns
        int ref_period;
        int gate_len;    // ps_clk cycles
        int adc_exp;
        int ref_exp;
    } row_t;

    // Expected count is gate_len * 100 ns / period rounded to nearest
    row_t rows [NUM_ROWS] = '{
        '{25, 40, 200,  800,  500},
        '{40, 70, 700, 1750, 1000},
        '{70, 25, 200,  286,  800},
        '{25, 40, 700, 2800, 1750}
    };

    logic      ps_clk;
    logic      arst_n;
    logic      adc_clk  = 1'b0;
    logic      ref_clk  = 1'b0;
    real       adc_half = 12.5;
    real       ref_half = 20.0;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    freq_mon_top #(.GATE_DEFAULT(GATE_DEFAULT)) DUT (
        .ps_clk     (ps_clk),
        .arst_n_i   (arst_n),
        .adc_clk_i  (adc_clk),
        .ref_clk_i  (ref_clk),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp)
    );

    initial begin
        ps_clk = 1'b0;
        forever #50 ps_clk = ~ps_clk;
    end

    // Measured clocks follow the current row
    always #(adc_half) adc_clk = ~adc_clk;
    always #(ref_half) ref_clk = ~ref_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [31:0] tol);
        logic [31:0] diff;
        diff = (got > exp) ? got - exp : exp - got;
        if ($isunknown(got) || diff > tol) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // One transfer with 0 to 3 cycles of B or R back-pressure
    task automatic bus_access(input bit is_wr, input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] wdata,
                              output logic [AXIL_DATA_W-1:0] rdata);
        int guard;
        int hold;
        @(negedge ps_clk);
        axil_req.awaddr  = addr;
        axil_req.araddr  = addr;
        axil_req.wdata   = wdata;
        axil_req.wstrb   = '1;
        axil_req.awvalid = is_wr;
        axil_req.wvalid  = is_wr;
        axil_req.arvalid = !is_wr;
        guard = 0;
        @(negedge ps_clk);
        while (!(is_wr ? axil_rsp.awready && axil_rsp.wready : axil_rsp.arready)) begin
            guard++;
            if (guard > HS_LIMIT) abort_run("The DUT never accepted the address");
            @(negedge ps_clk);
        end
        @(negedge ps_clk);  // Handshake on the edge just passed
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.arvalid = 1'b0;
        rdata = axil_rsp.rdata;
        hold  = $urandom_range(3, 0);
        for (int i = 0; i <= hold; i++) begin
            if (i > 0) @(negedge ps_clk);
            check_value(is_wr ? "bvalid" : "rvalid",
                        32'(is_wr ? axil_rsp.bvalid : axil_rsp.rvalid), 32'd1, 32'd0);
            // OKAY on both channels
            check_value("resp", 32'(is_wr ? axil_rsp.bresp : axil_rsp.rresp), 32'd0, 32'd0);
            if (!is_wr && i > 0) check_value("rdata", axil_rsp.rdata, rdata, 32'd0);
        end
        axil_req.bready = is_wr;
        axil_req.rready = !is_wr;
        @(negedge ps_clk);
        axil_req.bready = 1'b0;
        axil_req.rready = 1'b0;
        check_value("bvalid_rvalid", 32'({axil_rsp.bvalid, axil_rsp.rvalid}), 32'd0, 32'd0);
    endtask

    // Polls status until both meters report a new count
    task automatic wait_results();
        logic [AXIL_DATA_W-1:0] status;
        status = '0;
        while (status[1:0] != 2'b11) bus_access(RD, REG_STATUS, '0, status);
    endtask

    // Four gate intervals per row plus reset and register checks
    initial begin : watchdog
        int limit_ns;
        limit_ns = 400 * GATE_DEFAULT + 50000;
        foreach (rows[i]) limit_ns += 400 * rows[i].gate_len;
        #(limit_ns);
        abort_run("Watchdog expired, the tests did not finish in time");
    end

    initial begin : stimulus
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_DATA_W-1:0] prev;
        void'($urandom(SEED));
        axil_req = '0;
        arst_n   = 1'b0;
        repeat (16) @(posedge ps_clk);
        @(negedge ps_clk);
        check_value("handshake", 32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                    axil_rsp.arready, axil_rsp.rvalid}), 32'd0, 32'd0);
        arst_n = 1'b1;

        // First gate fires at once and its result lands after this read
        bus_access(RD, REG_STATUS, '0, data);
        check_value("status", data, 32'h0, 32'h0);
        bus_access(RD, REG_GATE_LEN, '0, data);
        check_value("gate_len", data, GATE_DEFAULT, 32'h0);

        bus_access(WR, REG_GATE_LEN, 32'h0000_0123, data);
        bus_access(RD, REG_GATE_LEN, '0, data);
        check_value("gate_len", data, 32'h123, 32'h0);
        bus_access(WR, 4'h6, 32'hffff_ffff, data);  // Unmapped
        bus_access(RD, 4'h6, '0, data);
        check_value("unmapped", data, 32'h0, 32'h0);
        bus_access(RD, REG_GATE_LEN, '0, data);
        check_value("gate_len", data, 32'h123, 32'h0);
        bus_access(RD, REG_ADC_FREQ, '0, prev);
        bus_access(WR, REG_ADC_FREQ, 32'hdead_beef, data);
        bus_access(RD, REG_ADC_FREQ, '0, data);
        check_value("adc_freq", data, prev, 32'h0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            adc_half = rows[r].adc_period / 2.0;
            ref_half = rows[r].ref_period / 2.0;
            bus_access(WR, REG_GATE_LEN, rows[r].gate_len, data);
            repeat (16) @(negedge ps_clk);  // Results from the old interval land
            bus_access(RD, REG_ADC_FREQ, '0, data);
            bus_access(RD, REG_REF_FREQ, '0, data);
            bus_access(RD, REG_STATUS, '0, data);
            check_value("status", data, 32'h0, 32'h0);
            wait_results();  // Partial interval is dropped
            bus_access(RD, REG_ADC_FREQ, '0, data);
            bus_access(RD, REG_STATUS, '0, data);
            check_value("status", data, 32'h2, 32'h0);
            bus_access(RD, REG_REF_FREQ, '0, data);
            bus_access(RD, REG_STATUS, '0, data);
            check_value("status", data, 32'h0, 32'h0);
            wait_results();
            bus_access(RD, REG_ADC_FREQ, '0, data);
            check_value("adc_freq", data, rows[r].adc_exp, 32'd1);
            bus_access(RD, REG_REF_FREQ, '0, data);
            check_value("ref_freq", data, rows[r].ref_exp, 32'd1);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb.f ====
freq_mon_pkg.sv
pulse_sync.sv
gate_timer.sv
clk_meter.sv
axil_regs.sv
freq_mon_top.sv
tb_freq_mon.sv

// ==== Makefile ====
SIM        := verilator
TOP        := tb_freq_mon
LINT_TOP   := freq_mon_top
FILELIST   := tb.f
SIM_FLAGS  := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
